//--- design/data_mem.sv
module data_mem #(
    parameter int mem_latency    = 3,
    parameter int mem_addr_width = 8
) (
    input  logic clk,
    input  logic rst,

    input  logic                              mem_req,
    input  logic                              mem_wr,
    input  logic [dcache_pkg::addr_width-1:0] mem_addr,
    input  logic [dcache_pkg::word_width-1:0] mem_wdata,
    output logic [dcache_pkg::word_width-1:0] mem_rdata,
    output logic                              mem_addr_ok,
    output logic                              mem_data_ok
);

    localparam int words     = 1 << mem_addr_width;
    localparam int cnt_width = $clog2(mem_latency + 1);

    logic [dcache_pkg::word_width-1:0] mem_q [words];

    // one access in flight
    logic                              busy;
    logic [cnt_width-1:0]              count;
    logic                              wr_q;
    logic [mem_addr_width-1:0]         addr_q;
    logic [dcache_pkg::word_width-1:0] wdata_q;

    // accept only when idle
    assign mem_addr_ok = mem_req && !busy;
    // last latency cycle
    assign mem_data_ok = busy && (count == '0);
    // read data valid with data_ok
    assign mem_rdata   = mem_q[addr_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (mem_addr_ok) begin
            busy  <= 1'b1;
            count <= cnt_width'(mem_latency - 1);
        end else if (mem_data_ok) begin
            busy <= 1'b0;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    // captured request, held while busy
    always_ff @(posedge clk) begin
        if (mem_addr_ok) begin
            wr_q    <= mem_wr;
            addr_q  <= mem_addr[dcache_pkg::offset_width +: mem_addr_width];
            wdata_q <= mem_wdata;
        end
    end

    // array starts at zero, write lands on data_ok
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < words; i++) begin
                mem_q[i] <= '0;
            end
        end else if (mem_data_ok && wr_q) begin
            mem_q[addr_q] <= wdata_q;
        end
    end

    // each data_ok pairs with an acceptance exactly mem_latency cycles back
    a_data_ok_in_flight: assert property (
        @(posedge clk) disable iff (rst)
        mem_data_ok |-> $past(mem_addr_ok, mem_latency)
    ) else $error("data_mem: mem_data_ok with no access in flight");

endmodule

//--- design/dcache_ctrl.sv
module dcache_ctrl #(
    parameter int index_width = 4
) (
    input  logic clk,
    input  logic rst,

    // core side
    input  logic                              cpu_req,
    input  logic                              cpu_wr,
    input  dcache_pkg::size_t                 cpu_size,
    input  logic [dcache_pkg::addr_width-1:0] cpu_addr,
    input  logic [dcache_pkg::word_width-1:0] cpu_wdata,
    output logic [dcache_pkg::word_width-1:0] cpu_rdata,
    output logic                              cpu_addr_ok,
    output logic                              cpu_data_ok,

    // way store lookup
    input  logic                              hit,
    input  logic                              sel_way,
    input  logic                              sel_dirty,
    input  logic [dcache_pkg::addr_width-index_width-dcache_pkg::offset_width-1:0] sel_tag,
    input  logic [dcache_pkg::word_width-1:0] sel_data,

    // way store update
    output logic                              line_we,
    output logic [dcache_pkg::word_width-1:0] line_wdata,
    output logic                              line_dirty,
    output logic                              touch,

    // memory side
    output logic                              mem_req,
    output logic                              mem_wr,
    output logic [dcache_pkg::addr_width-1:0] mem_addr,
    output logic [dcache_pkg::word_width-1:0] mem_wdata,
    input  logic [dcache_pkg::word_width-1:0] mem_rdata,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok
);

    dcache_pkg::state_t state;

    // memory took the address, waiting for data
    logic addr_acc;

    logic                              in_idle;
    logic                              in_read;
    logic                              hit_req;
    logic                              refill;
    logic [index_width-1:0]            index;
    logic [3:0]                        byte_mask;
    logic [dcache_pkg::word_width-1:0] bit_mask;
    logic [dcache_pkg::word_width-1:0] merge_base;

    assign in_idle = (state == dcache_pkg::idle);
    assign in_read = (state == dcache_pkg::read_mem);
    assign index   = cpu_addr[dcache_pkg::offset_width +: index_width];

    // hit served combinationally in idle
    assign hit_req = in_idle && cpu_req && hit;
    // refill word arrives
    assign refill  = in_read && mem_data_ok;

    // miss FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::idle;
        end else begin
            case (state)
                dcache_pkg::idle: begin
                    // dirty victim goes back to memory first
                    if (cpu_req && !hit) begin
                        state <= sel_dirty ? dcache_pkg::write_mem : dcache_pkg::read_mem;
                    end
                end
                dcache_pkg::write_mem: begin
                    if (mem_data_ok) begin
                        state <= dcache_pkg::read_mem;
                    end
                end
                dcache_pkg::read_mem: begin
                    if (mem_data_ok) begin
                        state <= dcache_pkg::idle;
                    end
                end
                default: begin
                    state <= dcache_pkg::idle;
                end
            endcase
        end
    end

    // mem_req drops once accepted, rises again after data_ok
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_acc <= 1'b0;
        end else if (mem_data_ok) begin
            addr_acc <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            addr_acc <= 1'b1;
        end
    end

    assign mem_req = !in_idle && !addr_acc;
    assign mem_wr  = (state == dcache_pkg::write_mem);

    // write-back goes to the victim's own address
    assign mem_addr = mem_wr ? {sel_tag, index, {dcache_pkg::offset_width{1'b0}}}
                             : {cpu_addr[dcache_pkg::addr_width-1:dcache_pkg::offset_width],
                                {dcache_pkg::offset_width{1'b0}}};
    assign mem_wdata = sel_data;

    // byte lanes of the store
    always_comb begin
        case (cpu_size)
            dcache_pkg::size_byte: byte_mask = 4'b0001 << cpu_addr[1:0];
            dcache_pkg::size_half: byte_mask = cpu_addr[1] ? 4'b1100 : 4'b0011;
            default:               byte_mask = 4'b1111;
        endcase
    end

    // loads keep the base word untouched
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            bit_mask[8*i +: 8] = {8{byte_mask[i] & cpu_wr}};
        end
    end

    // store merges into the refilled word or the hit word
    assign merge_base = in_read ? mem_rdata : sel_data;
    assign line_wdata = (merge_base & ~bit_mask) | (cpu_wdata & bit_mask);

    // line update on store hit or any refill
    assign line_we    = (hit_req && cpu_wr) || refill;
    assign line_dirty = cpu_wr;
    assign touch      = cpu_data_ok;

    // core acknowledges
    assign cpu_addr_ok = hit_req || (in_read && mem_req && mem_addr_ok);
    assign cpu_data_ok = hit_req || refill;
    assign cpu_rdata   = in_read ? mem_rdata : sel_data;

    // refill ack relies on the core still holding its request
    a_data_ok_req: assert property (
        @(posedge clk) disable iff (rst)
        cpu_data_ok |-> cpu_req
    ) else $error("dcache_ctrl: cpu_data_ok without cpu_req");

    // write-back only while the lookup still misses
    a_wr_in_write_mem: assert property (
        @(posedge clk) disable iff (rst)
        mem_wr |-> !hit
    ) else $error("dcache_ctrl: write-back while the lookup hits");

    // victim way must not move during a miss
    a_victim_stable: assert property (
        @(posedge clk) disable iff (rst)
        !in_idle |-> $stable(sel_way)
    ) else $error("dcache_ctrl: victim way changed during a miss");

endmodule

//--- design/dcache_pkg.sv
package dcache_pkg;

    // byte address and data word
    parameter int addr_width = 32;
    parameter int word_width = 32;

    // byte position inside one word
    parameter int offset_width = 2;

    // core request size
    // byte lane comes from addr[1:0]
    // halfword lane comes from addr[1]
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_t;

    // miss handling states
    // write_mem pushes a dirty victim out first
    // read_mem fetches the missing word and refills
    typedef enum logic [1:0] {
        idle      = 2'd0,
        write_mem = 2'd1,
        read_mem  = 2'd2
    } state_t;

endpackage

//--- design/dcache_top.sv
module dcache_top #(
    parameter int index_width    = 4,
    parameter int mem_latency    = 3,
    parameter int mem_addr_width = 8
) (
    input  logic clk,
    input  logic rst,

    input  logic                              cpu_req,
    input  logic                              cpu_wr,
    input  dcache_pkg::size_t                 cpu_size,
    input  logic [dcache_pkg::addr_width-1:0] cpu_addr,
    input  logic [dcache_pkg::word_width-1:0] cpu_wdata,
    output logic [dcache_pkg::word_width-1:0] cpu_rdata,
    output logic                              cpu_addr_ok,
    output logic                              cpu_data_ok
);

    localparam int tag_width = dcache_pkg::addr_width - index_width - dcache_pkg::offset_width;

    // controller to way store
    logic                              hit;
    logic                              sel_way;
    logic                              sel_dirty;
    logic [tag_width-1:0]              sel_tag;
    logic [dcache_pkg::word_width-1:0] sel_data;
    logic                              line_we;
    logic [dcache_pkg::word_width-1:0] line_wdata;
    logic                              line_dirty;
    logic                              touch;

    // controller to memory
    logic                              mem_req;
    logic                              mem_wr;
    logic [dcache_pkg::addr_width-1:0] mem_addr;
    logic [dcache_pkg::word_width-1:0] mem_wdata;
    logic [dcache_pkg::word_width-1:0] mem_rdata;
    logic                              mem_addr_ok;
    logic                              mem_data_ok;

    dcache_ctrl #(
        .index_width(index_width)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_size   (cpu_size),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_rdata  (cpu_rdata),
        .cpu_addr_ok(cpu_addr_ok),
        .cpu_data_ok(cpu_data_ok),
        .hit        (hit),
        .sel_way    (sel_way),
        .sel_dirty  (sel_dirty),
        .sel_tag    (sel_tag),
        .sel_data   (sel_data),
        .line_we    (line_we),
        .line_wdata (line_wdata),
        .line_dirty (line_dirty),
        .touch      (touch),
        .mem_req    (mem_req),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok)
    );

    // way store decodes the core address itself
    dcache_ways #(
        .index_width(index_width)
    ) u_ways (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .line_we   (line_we),
        .line_dirty(line_dirty),
        .touch     (touch),
        .line_wdata(line_wdata),
        .hit       (hit),
        .sel_way   (sel_way),
        .sel_dirty (sel_dirty),
        .sel_tag   (sel_tag),
        .sel_data  (sel_data)
    );

    data_mem #(
        .mem_latency   (mem_latency),
        .mem_addr_width(mem_addr_width)
    ) u_mem (
        .clk        (clk),
        .rst        (rst),
        .mem_req    (mem_req),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok)
    );

endmodule

//--- design/dcache_ways.sv
module dcache_ways #(
    parameter int index_width = 4
) (
    input  logic clk,
    input  logic rst,

    // lookup address straight from the core
    input  logic [dcache_pkg::addr_width-1:0] cpu_addr,

    // update strobes from the controller
    input  logic                              line_we,
    input  logic                              line_dirty,
    input  logic                              touch,
    input  logic [dcache_pkg::word_width-1:0] line_wdata,

    // lookup result
    output logic                              hit,
    output logic                              sel_way,
    output logic                              sel_dirty,
    output logic [dcache_pkg::addr_width-index_width-dcache_pkg::offset_width-1:0] sel_tag,
    output logic [dcache_pkg::word_width-1:0] sel_data
);

    localparam int sets      = 1 << index_width;
    localparam int tag_width = dcache_pkg::addr_width - index_width - dcache_pkg::offset_width;

    // per way state bits, one bit per set
    logic [sets-1:0] valid_q [2];
    logic [sets-1:0] dirty_q [2];

    // one bit per set, holds the way touched last
    logic [sets-1:0] ru_q;

    // tag and data arrays
    logic [tag_width-1:0]              tag_q  [2][sets];
    logic [dcache_pkg::word_width-1:0] data_q [2][sets];

    logic [index_width-1:0] index;
    logic [tag_width-1:0]   tag;
    logic [1:0]             hit_vec;

    // address split
    assign index = cpu_addr[dcache_pkg::offset_width +: index_width];
    assign tag   = cpu_addr[dcache_pkg::addr_width-1 -: tag_width];

    // per way compare
    assign hit_vec[0] = valid_q[0][index] && (tag_q[0][index] == tag);
    assign hit_vec[1] = valid_q[1][index] && (tag_q[1][index] == tag);
    assign hit        = |hit_vec;

    // way choice
    // on a hit the matching way
    // on a miss an empty way first, else the older one
    always_comb begin
        if (hit_vec != 2'b00) begin
            sel_way = hit_vec[1];
        end else if (!valid_q[0][index]) begin
            sel_way = 1'b0;
        end else if (!valid_q[1][index]) begin
            sel_way = 1'b1;
        end else begin
            sel_way = ~ru_q[index];
        end
    end

    // contents of the chosen way
    assign sel_dirty = dirty_q[sel_way][index];
    assign sel_tag   = tag_q[sel_way][index];
    assign sel_data  = data_q[sel_way][index];

    // control bits, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            ru_q       <= '0;
        end else begin
            if (line_we) begin
                valid_q[sel_way][index] <= 1'b1;
                dirty_q[sel_way][index] <= line_dirty;
            end
            // other way becomes the replacement candidate
            if (touch) begin
                ru_q[index] <= sel_way;
            end
        end
    end

    // tag and data words
    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_q[sel_way][index]  <= tag;
            data_q[sel_way][index] <= line_wdata;
        end
    end

    // refill must only ever land in a way that misses
    // otherwise one set would hold the same tag twice
    a_no_dup_tag: assert property (
        @(posedge clk) disable iff (rst)
        !(valid_q[0][index] && valid_q[1][index] && (tag_q[0][index] == tag_q[1][index]))
    ) else $error("dcache_ways: set %0d holds the same tag in both ways", index);

endmodule

//--- run.sh
#!/bin/sh
# build the dcache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dcache -f sources.f \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_dcache > sim.log 2>&1
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sources.f
design/dcache_pkg.sv
design/dcache_ways.sv
design/dcache_ctrl.sv
design/data_mem.sv
design/dcache_top.sv
verification/tb_clock.sv
verification/tb_dcache.sv

//--- verification/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held over three rising edges, released just after the third
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

//--- verification/tb_dcache.sv
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int index_width    = 4;
    localparam int mem_latency    = 3;
    localparam int mem_addr_width = 8;
    localparam int sets           = 1 << index_width;
    localparam int tag_width      = dcache_pkg::addr_width - index_width - dcache_pkg::offset_width;
    localparam int random_count   = 400;
    localparam int directed_count = 13;
    // worst case per request is a dirty miss, doubled for margin
    localparam int timeout_ns = (random_count + directed_count) * (2 * mem_latency + 4) * 40 * 2;

    logic                              clk;
    logic                              rst;
    logic                              cpu_req;
    logic                              cpu_wr;
    dcache_pkg::size_t                 cpu_size;
    logic [dcache_pkg::addr_width-1:0] cpu_addr;
    logic [dcache_pkg::word_width-1:0] cpu_wdata;
    logic [dcache_pkg::word_width-1:0] cpu_rdata;
    logic                              cpu_addr_ok;
    logic                              cpu_data_ok;

    // flat memory view plus shadow tags for hit prediction
    logic [dcache_pkg::word_width-1:0] model_mem [1 << mem_addr_width];
    logic                              shadow_valid [2][sets];
    logic [tag_width-1:0]              shadow_tag [2][sets];
    logic                              shadow_ru [sets];
    integer                            seed;

    tb_clock u_clock (
        .clk(clk),
        .rst(rst)
    );

    dcache_top #(
        .index_width   (index_width),
        .mem_latency   (mem_latency),
        .mem_addr_width(mem_addr_width)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_size   (cpu_size),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_rdata  (cpu_rdata),
        .cpu_addr_ok(cpu_addr_ok),
        .cpu_data_ok(cpu_data_ok)
    );

    task automatic check_word(input string name, input logic [dcache_pkg::word_width-1:0] got,
                              input logic [dcache_pkg::word_width-1:0] expected);
        if (got !== expected) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "bit mismatch");
        end
    endtask

    // store data already sits in its byte lanes
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] wdata,
                                                input dcache_pkg::size_t size,
                                                input logic [1:0] off);
        logic [31:0] res;
        res = old;
        case (size)
            dcache_pkg::size_byte: res[8*off +: 8] = wdata[8*off +: 8];
            dcache_pkg::size_half: res[16*off[1] +: 16] = wdata[16*off[1] +: 16];
            default:               res = wdata;
        endcase
        return res;
    endfunction

    function automatic logic way_matches(input logic way, input logic [31:0] addr);
        logic [index_width-1:0] idx;
        idx = addr[dcache_pkg::offset_width +: index_width];
        return shadow_valid[way][idx] && (shadow_tag[way][idx] == addr[31 -: tag_width]);
    endfunction

    // hit way, else empty way first, else the older way
    task automatic update_shadow(input logic [31:0] addr);
        logic [index_width-1:0] idx;
        logic                   way;
        idx = addr[dcache_pkg::offset_width +: index_width];
        if (way_matches(1'b0, addr) || way_matches(1'b1, addr)) begin
            way = way_matches(1'b1, addr);
        end else if (!shadow_valid[0][idx]) begin
            way = 1'b0;
        end else if (!shadow_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = !shadow_ru[idx];
        end
        shadow_valid[way][idx] = 1'b1;
        shadow_tag[way][idx]   = addr[31 -: tag_width];
        shadow_ru[idx]         = way;
    endtask

    // one core request, held until cpu_data_ok
    task automatic run_request(input logic wr, input dcache_pkg::size_t size,
                               input logic [31:0] addr, input logic [31:0] wdata);
        logic                      exp_hit;
        logic [mem_addr_width-1:0] word;
        int                        addr_ok_count;
        exp_hit = way_matches(1'b0, addr) || way_matches(1'b1, addr);
        word    = addr[dcache_pkg::offset_width +: mem_addr_width];
        @(posedge clk);
        #2;
        cpu_req   = 1'b1;
        cpu_wr    = wr;
        cpu_size  = size;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        // mid-cycle sample, acks only on a hit
        @(negedge clk);
        check_hit("cpu_data_ok", cpu_data_ok, exp_hit);
        check_hit("cpu_addr_ok", cpu_addr_ok, exp_hit);
        addr_ok_count = int'(cpu_addr_ok);
        while (!cpu_data_ok) begin
            @(negedge clk);
            addr_ok_count += int'(cpu_addr_ok);
        end
        // a miss still acknowledges the address once, at refill acceptance
        check_hit("cpu_addr_ok single pulse", addr_ok_count == 1, 1'b1);
        if (wr) begin
            model_mem[word] = merge_store(model_mem[word], wdata, size, addr[1:0]);
        end else begin
            check_word("cpu_rdata", cpu_rdata, model_mem[word]);
        end
        update_shadow(addr);
        @(posedge clk);
        #2;
        cpu_req = 1'b0;
    endtask

    task automatic run_random_mix();
        logic [31:0]       rnd;
        logic [31:0]       pick;
        dcache_pkg::size_t size;
        logic [1:0]        off;
        for (int n = 0; n < random_count; n++) begin
            rnd  = $random(seed);
            pick = rnd % 32'd3;
            size = dcache_pkg::size_t'(pick[1:0]);
            rnd  = $random(seed);
            // lane offset follows the alignment of the size
            case (size)
                dcache_pkg::size_byte: off = rnd[1:0];
                dcache_pkg::size_half: off = {rnd[1], 1'b0};
                default:               off = 2'b00;
            endcase
            run_request(rnd[16], size, {22'd0, rnd[15:8], off}, $random(seed));
        end
    endtask

    // watchdog
    initial begin
        #(timeout_ns);
        $display("timeout: the cache stopped answering core requests");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed      = 62;
        cpu_req   = 1'b0;
        cpu_wr    = 1'b0;
        cpu_size  = dcache_pkg::size_word;
        cpu_addr  = '0;
        cpu_wdata = '0;
        for (int i = 0; i < (1 << mem_addr_width); i++) begin
            model_mem[i] = '0;
        end
        for (int s = 0; s < sets; s++) begin
            shadow_valid[0][s] = 1'b0;
            shadow_valid[1][s] = 1'b0;
            shadow_ru[s]       = 1'b0;
        end
        wait (!rst);
        @(negedge clk);
        check_hit("cpu_addr_ok", cpu_addr_ok, 1'b0);
        check_hit("cpu_data_ok", cpu_data_ok, 1'b0);

        // cold load misses and reads zero
        run_request(1'b0, dcache_pkg::size_word, 32'h0000_0030, '0);

        // store then load, all three sizes
        run_request(1'b1, dcache_pkg::size_word, 32'h0000_0104, 32'h1234_5678);
        run_request(1'b0, dcache_pkg::size_word, 32'h0000_0104, '0);
        run_request(1'b1, dcache_pkg::size_half, 32'h0000_0106, 32'habcd_0000);
        run_request(1'b0, dcache_pkg::size_word, 32'h0000_0104, '0);
        run_request(1'b1, dcache_pkg::size_byte, 32'h0000_0105, 32'h0000_ef00);
        run_request(1'b0, dcache_pkg::size_word, 32'h0000_0104, '0);

        // three tags on set 5, first one goes out dirty
        run_request(1'b1, dcache_pkg::size_word, 32'h0000_0214, 32'haaaa_0001);
        run_request(1'b1, dcache_pkg::size_word, 32'h0000_0254, 32'hbbbb_0002);
        run_request(1'b1, dcache_pkg::size_word, 32'h0000_0294, 32'hcccc_0003);
        run_request(1'b0, dcache_pkg::size_word, 32'h0000_0214, '0);
        run_request(1'b0, dcache_pkg::size_word, 32'h0000_0294, '0);
        run_request(1'b0, dcache_pkg::size_word, 32'h0000_0254, '0);

        run_random_mix();

        repeat (2) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule
